// ==== subsys_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// GPIO subsystem shared definitions
// Bus widths, register map, opcodes and pipeline payload structs
//////////////////////////////////////////////////////////////////////

`default_nettype none

package subsys_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  parameter int XLEN         = 32; // Bus data and GPIO port width
  parameter int ADDR_W       = 12; // Peripheral bus address width
  parameter int INSPECT_PC_W = 30; // PC bits shown in inspect mode

  // GPIO register map
  parameter logic [ADDR_W-1:0] OFS_IVAL = 12'h000; // Pad input value, read only
  parameter logic [ADDR_W-1:0] OFS_OVAL = 12'h004; // Output value
  parameter logic [ADDR_W-1:0] OFS_OE   = 12'h008; // Output enable

  // Decoded register access
  typedef enum logic [1:0] {
    OP_RD_IVAL = 2'd0,
    OP_OVAL    = 2'd1,
    OP_OE      = 2'd2,
    OP_BAD     = 2'd3  // Unmapped or misaligned offset
  } gpio_op_e;

  //////////////////////////////////////////////////////////////////////
  // Pipeline payloads

  // Command from the bus master
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              read;
    logic [XLEN-1:0]   wdata;
    logic [XLEN/8-1:0] wmask;
  } icb_cmd_t;

  // Decoded request into the register stage
  typedef struct packed {
    gpio_op_e          op;
    logic              read;
    logic [XLEN-1:0]   wdata;
    logic [XLEN/8-1:0] wmask;
  } gpio_req_t;

  typedef struct packed {
    logic            err;
    logic [XLEN-1:0] rdata;
  } icb_rsp_t;

endpackage

`default_nettype wire

// ==== gpio_cmd_decode.sv ====
//////////////////////////////////////////////////////////////////////
// GPIO command decode stage
// Registers a bus command and turns its offset into an opcode
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module gpio_cmd_decode (
  input  logic                  clk,
  input  logic                  rst,

  // Bus command strobe
  input  logic                  cmd_valid,
  input  subsys_pkg::icb_cmd_t  cmd,

  // Decoded request to the register stage
  output logic                  req_valid,
  output subsys_pkg::gpio_req_t req
);

  import subsys_pkg::*;

  gpio_op_e op_dec;

  //////////////////////////////////////////////////////////////////////
  // Offset decode

  // Exact match only, so misaligned offsets land on OP_BAD
  always_comb begin
    case (cmd.addr)
      OFS_IVAL: op_dec = OP_RD_IVAL;
      OFS_OVAL: op_dec = OP_OVAL;
      OFS_OE:   op_dec = OP_OE;
      default:  op_dec = OP_BAD;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Request register

  always_ff @(posedge clk) begin
    if (rst) begin
      req_valid <= 1'b0;
    end else begin
      req_valid <= cmd_valid; // One cycle strobe, no back-pressure
    end
  end

  // Payload only loads on a command
  always_ff @(posedge clk) begin
    if (cmd_valid) begin
      req.op    <= op_dec;
      req.read  <= cmd.read;
      req.wdata <= cmd.wdata;
      req.wmask <= cmd.wmask;
    end
  end

endmodule

`default_nettype wire

// ==== gpio_regs.sv ====
//////////////////////////////////////////////////////////////////////
// GPIO register stage
// Output value and enable registers, input sync and bus responses
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module gpio_regs #(
  parameter int XLEN = subsys_pkg::XLEN
) (
  input  logic                  clk,
  input  logic                  rst,

  // Decoded request
  input  logic                  req_valid,
  input  subsys_pkg::gpio_req_t req,

  // Raw pad inputs
  input  logic [XLEN-1:0]       gpio_ival,

  // Bus response
  output logic                  rsp_valid,
  output subsys_pkg::icb_rsp_t  rsp,

  // Register values toward the pad stage
  output logic [XLEN-1:0]       reg_oval,
  output logic [XLEN-1:0]       reg_oe
);

  import subsys_pkg::*;

  localparam int NBYTES = XLEN / 8;

  logic [XLEN-1:0] ival_meta;
  logic [XLEN-1:0] ival_sync;
  logic [XLEN-1:0] bit_mask;
  logic            wr_oval;
  logic            wr_oe;
  icb_rsp_t        rsp_nxt;

  //////////////////////////////////////////////////////////////////////
  // Pad input synchronizer
  always_ff @(posedge clk) begin
    ival_meta <= gpio_ival;
    ival_sync <= ival_meta;
  end

  // Byte enables widened to one bit per data bit
  always_comb begin
    for (int b = 0; b < NBYTES; b++) begin
      bit_mask[8*b +: 8] = {8{req.wmask[b]}};
    end
  end

  assign wr_oval = req_valid && !req.read && (req.op == OP_OVAL);
  assign wr_oe   = req_valid && !req.read && (req.op == OP_OE);

  //////////////////////////////////////////////////////////////////////
  // Output registers
  always_ff @(posedge clk) begin
    if (rst) begin
      reg_oval <= '0;
      reg_oe   <= '0;
    end else begin
      if (wr_oval) reg_oval <= (reg_oval & ~bit_mask) | (req.wdata & bit_mask);
      if (wr_oe)   reg_oe   <= (reg_oe & ~bit_mask) | (req.wdata & bit_mask);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Response

  // Reads see the register value from before this request
  always_comb begin
    rsp_nxt.err   = 1'b0;
    rsp_nxt.rdata = '0;
    case (req.op)
      OP_RD_IVAL: begin
        if (req.read) rsp_nxt.rdata = ival_sync;
        else          rsp_nxt.err   = 1'b1; // Input register is read only
      end
      OP_OVAL: if (req.read) rsp_nxt.rdata = reg_oval;
      OP_OE:   if (req.read) rsp_nxt.rdata = reg_oe;
      default: rsp_nxt.err = 1'b1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= req_valid; // Exactly one response per request
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid) rsp <= rsp_nxt;
  end

endmodule

`default_nettype wire

// ==== pad_inspect_mux.sv ====
//////////////////////////////////////////////////////////////////////
// GPIO pad drive stage
// Registers pad outputs, with the inspect-mode debug override
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module pad_inspect_mux #(
  parameter int XLEN         = subsys_pkg::XLEN,
  parameter int INSPECT_PC_W = subsys_pkg::INSPECT_PC_W
) (
  input  logic                    clk,
  input  logic                    rst,

  // From the register stage
  input  logic [XLEN-1:0]         reg_oval,
  input  logic [XLEN-1:0]         reg_oe,

  // Inspect sources
  input  logic                    inspect_mode,
  input  logic [INSPECT_PC_W-1:0] inspect_pc,
  input  logic                    req_valid,    // Bus activity bits
  input  logic                    rsp_valid,

  // Pads
  output logic [XLEN-1:0]         gpio_oval,
  output logic [XLEN-1:0]         gpio_oe
);

  localparam int PC_LO_W = 22; // PC bits below the activity bits

  logic [XLEN-1:0] insp_oval;

  //////////////////////////////////////////////////////////////////////
  // Inspect view of the pads
  always_comb begin
    insp_oval                          = '0;
    insp_oval[PC_LO_W-1:0]             = inspect_pc[PC_LO_W-1:0];
    insp_oval[PC_LO_W]                 = req_valid;
    insp_oval[PC_LO_W+1]               = rsp_valid;
    insp_oval[INSPECT_PC_W+1:PC_LO_W+2] = inspect_pc[INSPECT_PC_W-1:PC_LO_W]; // Upper PC
  end

  //////////////////////////////////////////////////////////////////////
  // Pad registers

  // The GPIO registers stay untouched, so leaving inspect mode
  // brings the normal pad values straight back
  always_ff @(posedge clk) begin
    if (rst) begin
      gpio_oval <= '0;
      gpio_oe   <= '0;
    end else if (inspect_mode) begin
      gpio_oval <= insp_oval;
      gpio_oe   <= '1; // Every pad forced to output
    end else begin
      gpio_oval <= reg_oval;
      gpio_oe   <= reg_oe;
    end
  end

endmodule

`default_nettype wire

// ==== subsys_main.sv ====
//////////////////////////////////////////////////////////////////////
// GPIO A subsystem top
// Decode, register and pad stages on one peripheral bus path
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module subsys_main #(
  parameter int XLEN         = subsys_pkg::XLEN,
  parameter int INSPECT_PC_W = subsys_pkg::INSPECT_PC_W
) (
  input  logic                    clk,
  input  logic                    rst,

  // Peripheral bus
  input  logic                    cmd_valid,
  input  subsys_pkg::icb_cmd_t    cmd,
  output logic                    rsp_valid,
  output subsys_pkg::icb_rsp_t    rsp,

  // GPIO A pads
  input  logic [XLEN-1:0]         gpio_ival,
  output logic [XLEN-1:0]         gpio_oval,
  output logic [XLEN-1:0]         gpio_oe,

  // Debug view
  input  logic                    inspect_mode,
  input  logic [INSPECT_PC_W-1:0] inspect_pc
);

  import subsys_pkg::*;

  logic            req_valid;
  gpio_req_t       req;
  logic [XLEN-1:0] reg_oval;
  logic [XLEN-1:0] reg_oe;

  //////////////////////////////////////////////////////////////////////
  // Pipeline stages
  gpio_cmd_decode i_gpio_cmd_decode (
    .clk       (clk),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .req_valid (req_valid),
    .req       (req)
  );

  gpio_regs #(
    .XLEN (XLEN)
  ) i_gpio_regs (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req       (req),
    .gpio_ival (gpio_ival),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .reg_oval  (reg_oval),
    .reg_oe    (reg_oe)
  );

  // Bus strobes double as the inspect activity bits
  pad_inspect_mux #(
    .XLEN         (XLEN),
    .INSPECT_PC_W (INSPECT_PC_W)
  ) i_pad_inspect_mux (
    .clk          (clk),
    .rst          (rst),
    .reg_oval     (reg_oval),
    .reg_oe       (reg_oe),
    .inspect_mode (inspect_mode),
    .inspect_pc   (inspect_pc),
    .req_valid    (req_valid),
    .rsp_valid    (rsp_valid),
    .gpio_oval    (gpio_oval),
    .gpio_oe      (gpio_oe)
  );

endmodule

`default_nettype wire

// ==== tb_subsys_main.sv ====
//////////////////////////////////////////////////////////////////////
// GPIO A subsystem testbench
// Replays the golden step file and checks bus responses and pads
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_subsys_main;

  import subsys_pkg::*;

  localparam int NLINES     = 29;   // Data lines in the golden file
  localparam int NFIELDS    = 13;
  localparam int TIMEOUT_NS = NLINES * 4 + 200;

  // Golden file columns
  localparam int F_MODE  = 0;
  localparam int F_CV    = 1;
  localparam int F_ADDR  = 2;
  localparam int F_RD    = 3;
  localparam int F_WDATA = 4;
  localparam int F_WMASK = 5;
  localparam int F_IVAL  = 6;
  localparam int F_PC    = 7;
  localparam int F_KIND  = 8;
  localparam int F_ERR   = 9;
  localparam int F_RDATA = 10;
  localparam int F_OVAL  = 11;
  localparam int F_OE    = 12;

  localparam logic [31:0] KIND_RSP = 32'd1; // Response two cycles later
  localparam logic [31:0] KIND_PAD = 32'd2; // Pads on this very line

  logic                    clk;
  logic                    rst;
  logic                    cmd_valid;
  icb_cmd_t                cmd;
  logic                    rsp_valid;
  icb_rsp_t                rsp;
  logic [XLEN-1:0]         gpio_ival;
  logic [XLEN-1:0]         gpio_oval;
  logic [XLEN-1:0]         gpio_oe;
  logic                    inspect_mode;
  logic [INSPECT_PC_W-1:0] inspect_pc;

  logic [31:0]     gold [0:NLINES*NFIELDS-1];
  logic            sent_cmd  [0:NLINES-1];
  logic            has_model [0:NLINES-1]; // Read of OVAL or OE
  logic [31:0]     model_rd  [0:NLINES-1];
  logic [XLEN-1:0] model_oval;              // Reference copies of the registers
  logic [XLEN-1:0] model_oe;
  int              errors;
  int              nchecks;

  subsys_main #(
    .XLEN         (XLEN),
    .INSPECT_PC_W (INSPECT_PC_W)
  ) i_subsys_main (
    .clk          (clk),
    .rst          (rst),
    .cmd_valid    (cmd_valid),
    .cmd          (cmd),
    .rsp_valid    (rsp_valid),
    .rsp          (rsp),
    .gpio_ival    (gpio_ival),
    .gpio_oval    (gpio_oval),
    .gpio_oe      (gpio_oe),
    .inspect_mode (inspect_mode),
    .inspect_pc   (inspect_pc)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  function automatic logic [31:0] word_at(input int line, input int f);
    return gold[line*NFIELDS + f];
  endfunction

  // Write data lands only in the enabled bytes
  function automatic logic [XLEN-1:0] merge_bytes(input logic [XLEN-1:0] old,
                                                  input logic [XLEN-1:0] wdata,
                                                  input logic [XLEN/8-1:0] wmask);
    logic [XLEN-1:0] res;
    res = old;
    for (int b = 0; b < XLEN/8; b++) begin
      if (wmask[b]) res[8*b +: 8] = wdata[8*b +: 8];
    end
    return res;
  endfunction

  task automatic check_eq(input int line, input string what,
                          input logic [31:0] got, input logic [31:0] exp);
    nchecks++;
    assert (got === exp) else begin
      errors++;
      $display("error at %0t ns: line %0d %s got %h expected %h",
               $time, line, what, got, exp);
    end
  endtask

  task automatic drive_line(input int k);
    logic [31:0] w [NFIELDS];
    for (int f = 0; f < NFIELDS; f++) w[f] = word_at(k, f);
    inspect_mode = w[F_MODE][0];
    cmd_valid    = w[F_CV][0];
    cmd.addr     = w[F_ADDR][ADDR_W-1:0];
    cmd.read     = w[F_RD][0];
    cmd.wdata    = w[F_WDATA];
    cmd.wmask    = w[F_WMASK][XLEN/8-1:0];
    gpio_ival    = w[F_IVAL];
    inspect_pc   = w[F_PC][INSPECT_PC_W-1:0];
    sent_cmd[k]  = cmd_valid;
    has_model[k] = 1'b0;
    model_rd[k]  = '0;
    if (cmd_valid && cmd.read) begin
      has_model[k] = (cmd.addr == OFS_OVAL) || (cmd.addr == OFS_OE);
      model_rd[k]  = (cmd.addr == OFS_OE) ? model_oe : model_oval;
    end else if (cmd_valid) begin
      if (cmd.addr == OFS_OVAL) model_oval = merge_bytes(model_oval, cmd.wdata, cmd.wmask);
      if (cmd.addr == OFS_OE)   model_oe   = merge_bytes(model_oe, cmd.wdata, cmd.wmask);
    end
  endtask

  // Response of line k-2, then the pad check of line k
  task automatic check_step(input int k);
    logic prev_cmd;
    prev_cmd = (k >= 2) ? sent_cmd[k-2] : 1'b0;
    check_eq(k, "rsp_valid", {31'b0, rsp_valid}, {31'b0, prev_cmd});
    if (k >= 2 && word_at(k-2, F_KIND) == KIND_RSP) begin
      check_eq(k - 2, "err", {31'b0, rsp.err}, word_at(k-2, F_ERR));
      check_eq(k - 2, "rdata", rsp.rdata, word_at(k-2, F_RDATA));
      if (has_model[k-2]) check_eq(k - 2, "rdata vs model", rsp.rdata, model_rd[k-2]);
    end
    if (k < NLINES && word_at(k, F_KIND) == KIND_PAD) begin
      check_eq(k, "gpio_oval", gpio_oval, word_at(k, F_OVAL));
      check_eq(k, "gpio_oe", gpio_oe, word_at(k, F_OE));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  initial begin
    errors       = 0;
    nchecks      = 0;
    rst          = 1'b1;
    cmd_valid    = 1'b0;
    cmd          = '0;
    gpio_ival    = '0;
    inspect_mode = 1'b0;
    inspect_pc   = '0;
    model_oval   = '0;
    model_oe     = '0;
    $readmemh("subsys_golden.txt", gold);
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int k = 0; k < NLINES + 2; k++) begin
      @(negedge clk);
      check_step(k);
      if (k < NLINES) begin
        drive_line(k);
      end else begin
        cmd_valid = 1'b0; // Drain the last responses
      end
    end
    $display("checks: %0d, errors: %0d", nchecks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== subsys_golden.txt ====
// mode cmd_valid addr read wdata wmask ival pc | kind err rdata oval oe
// kind 0 none, 1 response two cycles after the line, 2 pads on the line
0 0 000 0 00000000 0 A5C30F1E 00000000 2 0 00000000 00000000 00000000
0 1 004 1 00000000 0 A5C30F1E 00000000 1 0 00000000 00000000 00000000
0 1 008 1 00000000 0 A5C30F1E 00000000 1 0 00000000 00000000 00000000
0 1 004 0 DEADBEEF 5 A5C30F1E 00000000 1 0 00000000 00000000 00000000
0 1 004 1 00000000 0 A5C30F1E 00000000 1 0 00AD00EF 00000000 00000000
0 0 000 0 00000000 0 A5C30F1E 00000000 0 0 00000000 00000000 00000000
0 0 000 0 00000000 0 A5C30F1E 00000000 2 0 00000000 00AD00EF 00000000
0 1 004 0 12345678 A A5C30F1E 00000000 1 0 00000000 00000000 00000000
0 1 008 0 FFFF0000 F A5C30F1E 00000000 1 0 00000000 00000000 00000000
0 1 004 1 00000000 0 A5C30F1E 00000000 1 0 12AD56EF 00000000 00000000
0 1 008 1 00000000 0 A5C30F1E 00000000 1 0 FFFF0000 00000000 00000000
0 0 000 0 00000000 0 A5C30F1E 00000000 2 0 00000000 12AD56EF FFFF0000
0 1 000 1 00000000 0 A5C30F1E 00000000 1 0 A5C30F1E 00000000 00000000
0 1 000 0 FFFFFFFF F A5C30F1E 00000000 1 1 00000000 00000000 00000000
0 1 00C 1 00000000 0 A5C30F1E 00000000 1 1 00000000 00000000 00000000
0 1 006 0 FFFFFFFF F A5C30F1E 00000000 1 1 00000000 00000000 00000000
0 1 004 1 00000000 0 0F0F5A5A 00000000 1 0 12AD56EF 00000000 00000000
0 1 008 1 00000000 0 0F0F5A5A 00000000 1 0 FFFF0000 00000000 00000000
0 0 000 0 00000000 0 0F0F5A5A 00000000 0 0 00000000 00000000 00000000
0 1 000 1 00000000 0 0F0F5A5A 00000000 1 0 0F0F5A5A 00000000 00000000
1 0 000 0 00000000 0 0F0F5A5A 12345678 0 0 00000000 00000000 00000000
1 0 000 0 00000000 0 0F0F5A5A 12345678 0 0 00000000 00000000 00000000
1 0 000 0 00000000 0 0F0F5A5A 12345678 0 0 00000000 00000000 00000000
1 0 000 0 00000000 0 0F0F5A5A 12345678 2 0 00000000 48345678 FFFFFFFF
1 0 000 0 00000000 0 0F0F5A5A 3FC00001 0 0 00000000 00000000 00000000
1 0 000 0 00000000 0 0F0F5A5A 3FC00001 2 0 00000000 FF000001 FFFFFFFF
0 0 000 0 00000000 0 0F0F5A5A 3FC00001 0 0 00000000 00000000 00000000
0 0 000 0 00000000 0 0F0F5A5A 3FC00001 2 0 00000000 12AD56EF FFFF0000
0 0 000 0 00000000 0 0F0F5A5A 3FC00001 0 0 00000000 00000000 00000000

// ==== project.f ====
subsys_pkg.sv
gpio_cmd_decode.sv
gpio_regs.sv
pad_inspect_mux.sv
subsys_main.sv
tb_subsys_main.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the GPIO A subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_subsys_main -f project.f -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
  exit 0
fi
exit 1
